// File: testbench/acq_input.dat
# buf_size post_trig chan pre_samples init_trig exp_trig, all hex
# init_trig ffffffff keeps the counter running on from the last run
010 005 0a 006 00000005 00000005
008 00c 03 009 ffffffff 00000006
005 007 1b 000 00000064 00000064
000 010 ff 00e ffffffff 00000065
003 001 02 002 ffffffff 00000066
007 000 44 00b fffffffe fffffffe
001 003 09 004 ffffffff ffffffff
020 025 80 030 ffffffff 00000000

// File: testbench/channel_checker.sv
`timescale 1ns/1ns
`include "wfd5_defs.svh"

module channel_checker (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`WFD5_SAMPLE_W-1:0] sample,
  input  logic                      sample_valid,
  input  logic                      acq_arm,
  input  logic                      acq_trig,
  input  logic                      acq_done,
  input  wfd5_pkg::apb_req_t        apb_req,
  input  wfd5_pkg::apb_rsp_t        apb_rsp,
  input  logic [31:0]               exp_trig,     // header trigger number of this run
  output int                        check_count,
  output int                        error_count
);

  logic [`WFD5_SAMPLE_W-1:0] log_q [$];   // samples since the last arm
  logic [31:0]               hdr_q [$];   // what the header fifo should hold
  logic [31:0]               exp_mem [4096];
  bit                        exp_valid [4096];  // address written at least once
  logic [11:0]               bs_m;
  logic [11:0]               post_m;
  logic [7:0]                chan_m;
  logic [31:0]               init_m;
  logic [31:0]               cur_m;       // trigger counter model
  bit                        run_m, trig_m, done_m;
  bit                        armed, trig_seen, done_q;
  int                        pre_words;   // pairs finished before the trigger cycle
  int                        wait_n;      // access cycles without pready

  initial begin
    check_count = 0;
    error_count = 0;
  end

  function automatic logic [15:0] sign_extend(input logic [`WFD5_SAMPLE_W-1:0] s);
    sign_extend = 16'($signed(s));
  endfunction

  function automatic bit is_mapped(input logic [15:0] a);
    is_mapped = (a <= `WFD5_REG_HDR_POP && a[1:0] == 2'b00) ||
                (a >= `WFD5_MEM_BASE && a < `WFD5_MEM_BASE + 16'h4000);
  endfunction

  ////////////////////////////////////////
  // acquisition model and apb compare
  always @(posedge clk) begin : watch
    logic [15:0] a;
    logic [31:0] exp_val;
    bit          exp_err;
    bit          chk_val;
    int          total, bs_eff, k;
    int          exp_wait;
    if (reset) begin
      log_q.delete();
      hdr_q.delete();
      {bs_m, post_m, chan_m, init_m, cur_m} = '0;  // buffer size 0 is the full 4096
      {run_m, trig_m, done_m, armed, trig_seen, done_q} = '0;
      wait_n = 0;
    end else begin
      // done holds from the end of a run to the next arm, low before the trigger
      if ((done_m && acq_done !== 1'b1) || (!done_m && !trig_seen && acq_done !== 1'b0)) begin
        $display("error acq_done expected %h got %h", done_m, acq_done);
        error_count++;
      end
      if (acq_arm) begin
        log_q.delete();  // sample in the arm cycle is dropped
        {armed, run_m} = 2'b11;
        {trig_seen, trig_m, done_m} = '0;
      end else begin
        if (armed && !trig_seen && acq_trig) begin
          trig_seen = 1'b1;
          trig_m    = 1'b1;
          pre_words = log_q.size() / 2;  // word written now still counts as pre-trigger
        end
        if (sample_valid) log_q.push_back(sample);
      end
      if (acq_done && !done_q && armed) begin
        total  = pre_words + post_m;
        bs_eff = (bs_m == 0) ? 4096 : bs_m;
        if (log_q.size() < 2 * total) begin
          $display("only %0d samples logged for %0d words", log_q.size(), total);
          error_count++;
        end else begin
          for (k = 0; k < total; k++) begin
            exp_mem[k % bs_eff]   = {sign_extend(log_q[2*k+1]), sign_extend(log_q[2*k])};
            exp_valid[k % bs_eff] = 1'b1;  // later pair on top
          end
        end
        hdr_q.push_back({24'h0, chan_m});
        hdr_q.push_back(exp_trig);
        hdr_q.push_back(32'((total - 1) % bs_eff));  // last address written
        cur_m = exp_trig + 1;
        {armed, run_m, done_m} = 3'b001;
      end
      done_q = acq_done;

      if (apb_req.psel && apb_req.penable && !apb_rsp.pready) wait_n++;

      // one compare per finished transfer
      if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
        a       = apb_req.paddr;
        exp_err = !is_mapped(a) ||
                  (apb_req.pwrite && !(a <= `WFD5_REG_INIT_TRIG && a[1:0] == 2'b00)) ||
                  (!apb_req.pwrite && a == `WFD5_REG_HDR_POP && hdr_q.size() == 0);
        // only window reads wait, and for one cycle
        exp_wait = (!apb_req.pwrite && a >= `WFD5_MEM_BASE &&
                    a < `WFD5_MEM_BASE + 16'h4000) ? 1 : 0;
        check_count++;
        if (wait_n != exp_wait) begin
          $display("error pready wait at %h expected %h got %h", a, exp_wait, wait_n);
          error_count++;
        end
        wait_n = 0;
        if (apb_rsp.pslverr !== exp_err) begin
          $display("error pslverr at %h expected %h got %h", a, exp_err, apb_rsp.pslverr);
          error_count++;
        end
        chk_val = 1'b0;
        exp_val = '0;
        if (apb_req.pwrite && !exp_err) begin
          case (a)
            `WFD5_REG_BUF_SIZE:  bs_m   = apb_req.pwdata[11:0];
            `WFD5_REG_POST_TRIG: post_m = apb_req.pwdata[11:0];
            `WFD5_REG_CHAN_NUM:  chan_m = apb_req.pwdata[7:0];
            `WFD5_REG_INIT_TRIG: begin
              init_m = apb_req.pwdata;
              cur_m  = apb_req.pwdata;  // counter loads a cycle later
            end
            default: ;
          endcase
        end else if (!apb_req.pwrite && (!exp_err || a == `WFD5_REG_HDR_POP)) begin
          chk_val = 1'b1;
          case (a)
            `WFD5_REG_BUF_SIZE:  exp_val = {20'h0, bs_m};
            `WFD5_REG_POST_TRIG: exp_val = {20'h0, post_m};
            `WFD5_REG_CHAN_NUM:  exp_val = {24'h0, chan_m};
            `WFD5_REG_INIT_TRIG: exp_val = init_m;
            `WFD5_REG_CUR_TRIG:  exp_val = cur_m;
            `WFD5_REG_STATUS:    exp_val = {28'h0, (hdr_q.size() == 0), done_m, trig_m, run_m};
            `WFD5_REG_HDR_POP: begin
              if (!exp_err) exp_val = hdr_q.pop_front();  // empty pop reads zero
            end
            default: begin
              k       = (int'(a) - int'(`WFD5_MEM_BASE)) / 4;
              chk_val = exp_valid[k];  // never written, contents unknown
              exp_val = exp_mem[k];
            end
          endcase
        end
        if (chk_val && apb_rsp.prdata !== exp_val) begin
          $display("error prdata at %h expected %h got %h", a, exp_val, apb_rsp.prdata);
          error_count++;
        end
      end
    end
  end

endmodule

// File: testbench/tb_channel_main.sv
`timescale 1ns/1ns
`include "wfd5_defs.svh"

module tb_channel_main;

  localparam int          APB_LIMIT  = 16;      // cycles allowed for pready
  localparam int          DONE_LIMIT = 20000;   // cycles allowed for acq_done
  localparam logic [31:0] KEEP_TRIG  = 32'hffff_ffff;

  logic                      clk;
  logic                      reset;
  logic [`WFD5_SAMPLE_W-1:0] sample;
  logic                      sample_valid;
  logic                      acq_arm;
  logic                      acq_trig;
  logic                      acq_done;
  wfd5_pkg::apb_req_t        apb_req;
  wfd5_pkg::apb_rsp_t        apb_rsp;
  logic [31:0]               exp_trig;   // header trigger number from the data file
  logic [31:0]               lcg_state;
  int                        check_count;
  int                        error_count;
  int                        run_failures;  // timeouts and a missing data file

  channel_main i_channel_main (
    .clk, .reset, .sample, .sample_valid,
    .acq_arm, .acq_trig, .acq_done, .apb_req, .apb_rsp
  );

  channel_checker i_channel_checker (
    .clk, .reset, .sample, .sample_valid, .acq_arm, .acq_trig, .acq_done,
    .apb_req, .apb_rsp, .exp_trig, .check_count, .error_count
  );

  always #5 clk = ~clk;  // 10 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic drive_sample();
    lcg_state    = lcg_next(lcg_state);
    sample       = lcg_state[28:16];  // 13 bits from the better upper end
    sample_valid = 1'b1;
  endtask

  ////////////////////////////////////////
  // apb master, setup phase then access until pready
  task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] data);
    int n;
    if (run_failures != 0) return;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!apb_rsp.pready && n < APB_LIMIT);
    if (!apb_rsp.pready) begin
      $display("timeout waiting for pready at address %h", addr);
      run_failures++;
    end
    @(negedge clk);
    apb_req = '0;  // bus idle
  endtask

  task automatic run_acquisition(input int pre_samples);
    int n;
    if (run_failures != 0) return;
    @(negedge clk);
    acq_arm = 1'b1;
    @(negedge clk);
    acq_arm = 1'b0;
    for (n = 0; n < pre_samples; n++) begin
      drive_sample();
      @(negedge clk);
    end
    acq_trig = 1'b1;  // level held until done
    n = 0;
    while (!acq_done && n < DONE_LIMIT) begin
      drive_sample();
      @(negedge clk);
      n++;
    end
    if (!acq_done) begin
      $display("timeout waiting for acq_done after %0d samples", n);
      run_failures++;
    end
    acq_trig     = 1'b0;
    sample_valid = 1'b0;
  endtask

  // header, counters, empty pop, then every buffer word
  task automatic read_results(input logic [11:0] bs);
    int words;
    int a;
    words = (bs == 0) ? 4096 : bs;
    apb_access(1'b0, `WFD5_REG_STATUS, '0);
    repeat (`WFD5_HDR_WORDS) apb_access(1'b0, `WFD5_REG_HDR_POP, '0);
    apb_access(1'b0, `WFD5_REG_CUR_TRIG, '0);
    apb_access(1'b0, `WFD5_REG_STATUS, '0);   // fifo drained
    apb_access(1'b0, `WFD5_REG_HDR_POP, '0);  // pop on empty
    for (a = 0; a < words; a++) apb_access(1'b0, 16'(`WFD5_MEM_BASE + 4 * a), '0);
  endtask

  ////////////////////////////////////////
  // main sequence
  initial begin
    int          fd;
    int          code;
    string       line;
    logic [31:0] bs, post, chan, pre, init, trig_no;
    clk          = 1'b0;
    reset        = 1'b1;
    sample       = '0;
    sample_valid = 1'b0;
    acq_arm      = 1'b0;
    acq_trig     = 1'b0;
    apb_req      = '0;
    exp_trig     = '0;
    lcg_state    = 32'hc8ce;
    run_failures = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // register readback and error responses
    apb_access(1'b1, `WFD5_REG_BUF_SIZE, 32'h0000_0abc);
    apb_access(1'b1, `WFD5_REG_POST_TRIG, 32'h0000_0123);
    apb_access(1'b1, `WFD5_REG_CHAN_NUM, 32'h0000_005a);
    apb_access(1'b1, `WFD5_REG_INIT_TRIG, 32'h1234_5678);
    apb_access(1'b0, `WFD5_REG_BUF_SIZE, '0);
    apb_access(1'b0, `WFD5_REG_POST_TRIG, '0);
    apb_access(1'b0, `WFD5_REG_CHAN_NUM, '0);
    apb_access(1'b0, `WFD5_REG_INIT_TRIG, '0);
    apb_access(1'b0, `WFD5_REG_CUR_TRIG, '0);
    apb_access(1'b1, `WFD5_REG_CUR_TRIG, 32'h0000_0001);  // read only
    apb_access(1'b0, 16'h001c, '0);  // holes in the map
    apb_access(1'b0, 16'h0002, '0);
    apb_access(1'b0, 16'h5000, '0);
    apb_access(1'b0, `WFD5_REG_HDR_POP, '0);
    apb_access(1'b0, `WFD5_REG_STATUS, '0);

    fd = $fopen("testbench/acq_input.dat", "r");
    if (fd == 0) begin
      $display("cannot open testbench/acq_input.dat");
      run_failures++;
    end else begin
      while (run_failures == 0 && !$feof(fd)) begin
        code = $fgets(line, fd);
        if (code == 0 || line.getc(0) == "#") continue;
        code = $sscanf(line, "%h %h %h %h %h %h", bs, post, chan, pre, init, trig_no);
        if (code != 6) continue;  // blank line
        apb_access(1'b1, `WFD5_REG_BUF_SIZE, bs);
        apb_access(1'b1, `WFD5_REG_POST_TRIG, post);
        apb_access(1'b1, `WFD5_REG_CHAN_NUM, chan);
        if (init != KEEP_TRIG) apb_access(1'b1, `WFD5_REG_INIT_TRIG, init);
        apb_access(1'b0, `WFD5_REG_BUF_SIZE, '0);
        apb_access(1'b0, `WFD5_REG_POST_TRIG, '0);
        apb_access(1'b0, `WFD5_REG_CHAN_NUM, '0);
        exp_trig = trig_no;
        run_acquisition(pre);
        read_results(bs[11:0]);
      end
      $fclose(fd);
    end

    $display("checks %0d  errors %0d  run failures %0d", check_count, error_count, run_failures);
    if (error_count == 0 && run_failures == 0 && check_count > 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: verilog/acquisition_control.sv
`timescale 1ns/1ns
`include "wfd5_defs.svh"

module acquisition_control (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    arm,            // one-cycle pulse
  input  logic                    trig,           // level, sampled each cycle
  input  wfd5_pkg::adc_word_t     word,
  input  logic                    word_valid,
  input  wfd5_pkg::acq_cfg_t      cfg,
  input  logic [31:0]             init_trig_num,
  input  logic                    init_trig_we,
  input  logic                    hdr_full,
  output wfd5_pkg::mem_wr_t       mem_wr,
  output logic                    hdr_push,
  output logic [`WFD5_WORD_W-1:0] hdr_data,
  output logic                    done,
  output logic [31:0]             cur_trig_num,
  output wfd5_pkg::acq_status_t   status
);

  localparam int IDX_W = $clog2(`WFD5_HDR_WORDS);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_HDR, ST_DONE} state_t;

  state_t                  state;
  logic [`WFD5_ADDR_W-1:0] wr_addr;    // next word goes here
  logic [`WFD5_ADDR_W-1:0] last_addr;  // last word actually written
  logic [`WFD5_ADDR_W-1:0] post_cnt;   // words taken since the trigger
  logic                    triggered;
  logic [IDX_W-1:0]        hdr_idx;    // which header word is next
  logic [31:0]             trig_num;
  logic                    post_done;

  // post-trigger quota used up, stop writing
  assign post_done = triggered && (post_cnt == cfg.post_trig_size);

  always_comb begin
    mem_wr.we   = (state == ST_RUN) && word_valid && !post_done;
    mem_wr.addr = wr_addr;
    mem_wr.data = word;
  end

  assign hdr_push = (state == ST_HDR) && !hdr_full;  // stall while full

  // header words in order
  always_comb begin
    case (hdr_idx)
      IDX_W'(0): hdr_data = {24'h0, cfg.channel_num};
      IDX_W'(1): hdr_data = trig_num;
      default:   hdr_data = {20'h0, last_addr};
    endcase
  end

  assign done         = (state == ST_DONE);  // held until the next arm
  assign cur_trig_num = trig_num;

  always_comb begin
    status.running   = (state == ST_RUN);
    status.triggered = triggered;
    status.done      = done;
    status.hdr_empty = 1'b0;  // filled in from the fifo by the register block
  end

  ////////////////////////////////////////
  // main fsm
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      wr_addr   <= '0;
      last_addr <= '0;
      post_cnt  <= '0;
      triggered <= 1'b0;
      hdr_idx   <= '0;
      trig_num  <= '0;
    end else begin
      if (arm) begin
        state     <= ST_RUN;  // a new run, whatever state we were in
        wr_addr   <= '0;
        post_cnt  <= '0;
        triggered <= 1'b0;
        hdr_idx   <= '0;
      end else begin
        case (state)
          ST_RUN: begin
            if (post_done) state <= ST_HDR;
            if (trig && !triggered) triggered <= 1'b1;  // word in this cycle is pre-trigger
            if (mem_wr.we) begin
              last_addr <= wr_addr;
              // a size of 0 wraps at 4095 through the subtraction
              wr_addr <= (wr_addr == cfg.buffer_size - 1'b1) ? '0 : wr_addr + 1'b1;
              if (triggered) post_cnt <= post_cnt + 1'b1;
            end
          end
          ST_HDR: begin
            if (hdr_push) begin
              if (hdr_idx == IDX_W'(`WFD5_HDR_WORDS - 1)) begin
                state    <= ST_DONE;
                trig_num <= trig_num + 1'b1;  // next event number
              end else begin
                hdr_idx <= hdr_idx + 1'b1;
              end
            end
          end
          default: ;  // idle and done wait for arm
        endcase
      end
      if (init_trig_we) trig_num <= init_trig_num;  // load beats the increment
    end
  end

  // writes stay inside the configured circular buffer
  a_wr_in_buffer: assert property (@(posedge clk) disable iff (reset)
    mem_wr.we |-> (cfg.buffer_size == '0) || (mem_wr.addr < cfg.buffer_size));

endmodule

// File: verilog/adc_data_mem.sv
`timescale 1ns/1ns
`include "wfd5_defs.svh"

module adc_data_mem (
  input  logic                    clk,
  input  wfd5_pkg::mem_wr_t       wr,       // from the acquisition fsm
  input  logic [`WFD5_ADDR_W-1:0] rd_addr,  // from the apb window
  output logic [`WFD5_WORD_W-1:0] rd_data   // one cycle after rd_addr
);

  logic [`WFD5_WORD_W-1:0] mem [2**`WFD5_ADDR_W];

  // write side
  always_ff @(posedge clk) begin
    if (wr.we) mem[wr.addr] <= wr.data;
  end

  // registered read, old data on a same-address collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: verilog/adc_sample_packer.sv
`timescale 1ns/1ns
`include "wfd5_defs.svh"

module adc_sample_packer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,         // arm pulse, restarts pairing
  input  logic [`WFD5_SAMPLE_W-1:0] sample,
  input  logic                     sample_valid,
  output wfd5_pkg::adc_word_t      word,
  output logic                     word_valid
);

  logic [`WFD5_SAMPLE_W-1:0] first_q;  // earlier sample of the pair
  logic                      have_first;

  // copy bit 12 into the top three bits
  function automatic logic [`WFD5_HALF_W-1:0] sext(input logic [`WFD5_SAMPLE_W-1:0] s);
    sext = {{(`WFD5_HALF_W - `WFD5_SAMPLE_W){s[`WFD5_SAMPLE_W-1]}}, s};
  endfunction

  // pairing control
  always_ff @(posedge clk) begin
    if (reset || start) begin
      have_first <= 1'b0;  // half a pair is dropped here
      word_valid <= 1'b0;
    end else begin
      word_valid <= sample_valid && have_first;
      if (sample_valid) have_first <= !have_first;
    end
  end

  // sample and word registers
  always_ff @(posedge clk) begin
    if (sample_valid && !have_first) first_q <= sample;
    if (sample_valid && have_first) begin
      word.lo <= sext(first_q);
      word.hi <= sext(sample);  // newest sample goes high
    end
  end

endmodule

// File: verilog/channel_main.sv
`timescale 1ns/1ns
`include "wfd5_defs.svh"

module channel_main (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`WFD5_SAMPLE_W-1:0] sample,        // over-range in bit 0
  input  logic                     sample_valid,
  input  logic                     acq_arm,       // pulse from the master
  input  logic                     acq_trig,
  output logic                     acq_done,
  input  wfd5_pkg::apb_req_t       apb_req,
  output wfd5_pkg::apb_rsp_t       apb_rsp
);

  wfd5_pkg::adc_word_t     word;
  logic                    word_valid;
  wfd5_pkg::mem_wr_t       mem_wr;
  logic                    hdr_push;
  logic [`WFD5_WORD_W-1:0] hdr_data;
  logic                    hdr_full;
  logic                    hdr_pop;
  logic [`WFD5_WORD_W-1:0] hdr_dout;
  logic                    hdr_empty;
  wfd5_pkg::acq_cfg_t      cfg;
  logic [31:0]             init_trig_num;
  logic                    init_trig_we;
  logic [31:0]             cur_trig_num;
  wfd5_pkg::acq_status_t   status;
  logic [`WFD5_ADDR_W-1:0] rd_addr;
  logic [`WFD5_WORD_W-1:0] rd_data;

  ////////////////////////////////////////
  // adc path
  adc_sample_packer i_adc_sample_packer (
    .clk, .reset,
    .start(acq_arm),  // arm restarts pairing
    .sample, .sample_valid,
    .word, .word_valid
  );

  acquisition_control i_acquisition_control (
    .clk, .reset,
    .arm(acq_arm), .trig(acq_trig),
    .word, .word_valid, .cfg,
    .init_trig_num, .init_trig_we, .hdr_full,
    .mem_wr, .hdr_push, .hdr_data,
    .done(acq_done), .cur_trig_num, .status
  );

  adc_data_mem i_adc_data_mem (
    .clk, .wr(mem_wr), .rd_addr, .rd_data
  );

  header_fifo i_header_fifo (
    .clk, .reset,
    .push(hdr_push), .din(hdr_data),
    .pop(hdr_pop), .dout(hdr_dout),
    .full(hdr_full), .empty(hdr_empty)
  );

  ////////////////////////////////////////
  // readout to the master
  readout_regs i_readout_regs (
    .clk, .reset, .apb_req, .cur_trig_num, .status,
    .rd_data, .hdr_dout, .hdr_empty,
    .apb_rsp, .cfg, .init_trig_num, .init_trig_we, .rd_addr, .hdr_pop
  );

endmodule

// File: verilog/header_fifo.sv
`timescale 1ns/1ns
`include "wfd5_defs.svh"

module header_fifo (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    push,
  input  logic [`WFD5_WORD_W-1:0] din,
  input  logic                    pop,
  output logic [`WFD5_WORD_W-1:0] dout,   // head word, always visible
  output logic                    full,
  output logic                    empty
);

  localparam int PTR_W = $clog2(`WFD5_HDR_DEPTH);

  logic [`WFD5_WORD_W-1:0] mem [`WFD5_HDR_DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [PTR_W:0]          count;   // one extra bit to reach depth
  logic                    do_push;
  logic                    do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign full    = (count == (PTR_W + 1)'(`WFD5_HDR_DEPTH));
  assign empty   = (count == '0);
  assign dout    = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  // pointers wrap on their own at a power-of-two depth
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  ////////////////////////////////////////
  // the fsm waits on full and the apb side checks empty
  a_no_push_full: assert property (@(posedge clk) disable iff (reset) full |-> !push);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

// File: verilog/readout_regs.sv
`timescale 1ns/1ns
`include "wfd5_defs.svh"

module readout_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  wfd5_pkg::apb_req_t      apb_req,
  input  logic [31:0]             cur_trig_num,
  input  wfd5_pkg::acq_status_t   status,
  input  logic [`WFD5_WORD_W-1:0] rd_data,
  input  logic [`WFD5_WORD_W-1:0] hdr_dout,
  input  logic                    hdr_empty,
  output wfd5_pkg::apb_rsp_t      apb_rsp,
  output wfd5_pkg::acq_cfg_t      cfg,
  output logic [31:0]             init_trig_num,
  output logic                    init_trig_we,
  output logic [`WFD5_ADDR_W-1:0] rd_addr,
  output logic                    hdr_pop
);

  logic                  access;      // apb access phase
  logic [15:0]           mem_off;     // byte offset into the window
  logic                  is_mem;
  logic                  mem_rd;
  logic                  mem_wait_q;  // wait state done, data on rd_data
  logic                  mapped;
  logic                  writable;
  logic                  hdr_rd;
  logic                  err;
  logic [31:0]           rd_val;
  wfd5_pkg::acq_status_t st;

  assign access  = apb_req.psel && apb_req.penable;
  assign mem_off = apb_req.paddr - `WFD5_MEM_BASE;
  assign is_mem  = (apb_req.paddr >= `WFD5_MEM_BASE) && (mem_off[15:14] == 2'b00);
  assign mem_rd  = is_mem && !apb_req.pwrite;
  assign rd_addr = mem_off[13:2];  // byte to word address

  ////////////////////////////////////////
  // address decode and read mux
  always_comb begin
    st           = status;
    st.hdr_empty = hdr_empty;  // straight from the fifo
    mapped       = 1'b1;
    writable     = 1'b0;
    hdr_rd       = 1'b0;
    case (apb_req.paddr)
      `WFD5_REG_BUF_SIZE: begin
        writable = 1'b1;
        rd_val   = {20'h0, cfg.buffer_size};
      end
      `WFD5_REG_POST_TRIG: begin
        writable = 1'b1;
        rd_val   = {20'h0, cfg.post_trig_size};
      end
      `WFD5_REG_CHAN_NUM: begin
        writable = 1'b1;
        rd_val   = {24'h0, cfg.channel_num};
      end
      `WFD5_REG_INIT_TRIG: begin
        writable = 1'b1;
        rd_val   = init_trig_num;
      end
      `WFD5_REG_CUR_TRIG: rd_val = cur_trig_num;  // read only
      `WFD5_REG_STATUS:   rd_val = {28'h0, st};
      `WFD5_REG_HDR_POP: begin
        hdr_rd = 1'b1;
        rd_val = hdr_empty ? '0 : hdr_dout;  // nothing to pop gives zero
      end
      default: begin
        mapped = is_mem;  // everything else is a hole
        rd_val = rd_data;
      end
    endcase
  end

  assign err = !mapped || (apb_req.pwrite && !writable) || (hdr_rd && hdr_empty);

  // window reads need one wait state, all else completes at once
  always_comb begin
    apb_rsp.pready  = access && (!mem_rd || mem_wait_q);
    apb_rsp.pslverr = apb_rsp.pready && err;
    apb_rsp.prdata  = (apb_rsp.pready && !apb_req.pwrite && !err) ? rd_val : '0;
  end

  assign hdr_pop = apb_rsp.pready && hdr_rd && !err;  // one pop per good read

  ////////////////////////////////////////
  // configuration registers
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.buffer_size    <= '0;  // 0 is the full 4096 words
      cfg.post_trig_size <= '0;
      cfg.channel_num    <= '0;
      init_trig_num      <= '0;
      init_trig_we       <= 1'b0;
      mem_wait_q         <= 1'b0;
    end else begin
      init_trig_we <= 1'b0;
      mem_wait_q   <= access && mem_rd && !mem_wait_q;
      if (access && apb_req.pwrite && writable) begin
        case (apb_req.paddr)
          `WFD5_REG_BUF_SIZE:  cfg.buffer_size    <= apb_req.pwdata[`WFD5_ADDR_W-1:0];
          `WFD5_REG_POST_TRIG: cfg.post_trig_size <= apb_req.pwdata[`WFD5_ADDR_W-1:0];
          `WFD5_REG_CHAN_NUM:  cfg.channel_num    <= apb_req.pwdata[7:0];
          `WFD5_REG_INIT_TRIG: begin
            init_trig_num <= apb_req.pwdata;
            init_trig_we  <= 1'b1;  // counter loads a cycle later
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: verilog/wfd5_defs.svh
`ifndef WFD5_DEFS_SVH
`define WFD5_DEFS_SVH

// data path widths
`define WFD5_SAMPLE_W 13  // raw adc sample, over-range in bit 0
`define WFD5_HALF_W   16  // sample after sign extension
`define WFD5_WORD_W   32  // two samples per memory word
`define WFD5_ADDR_W   12  // 4096 words of sample memory

// event header fifo
`define WFD5_HDR_DEPTH 16
`define WFD5_HDR_WORDS 3  // channel, trigger number, last address

// apb register map, byte offsets
`define WFD5_REG_BUF_SIZE  16'h0000
`define WFD5_REG_POST_TRIG 16'h0004
`define WFD5_REG_CHAN_NUM  16'h0008
`define WFD5_REG_INIT_TRIG 16'h000C
`define WFD5_REG_CUR_TRIG  16'h0010
`define WFD5_REG_STATUS    16'h0014
`define WFD5_REG_HDR_POP   16'h0018
`define WFD5_MEM_BASE      16'h1000  // word n at base + 4*n

`endif

// File: verilog/wfd5_pkg.sv
`include "wfd5_defs.svh"

package wfd5_pkg;

  // one memory word, later sample in the upper half
  typedef struct packed {
    logic [`WFD5_HALF_W-1:0] hi;
    logic [`WFD5_HALF_W-1:0] lo;
  } adc_word_t;

  // acquisition setup from the register block
  typedef struct packed {
    logic [`WFD5_ADDR_W-1:0] buffer_size;     // 0 means the full 4096
    logic [`WFD5_ADDR_W-1:0] post_trig_size;  // words kept after the trigger
    logic [7:0]              channel_num;
  } acq_cfg_t;

  // write port of the sample memory
  typedef struct packed {
    logic                    we;
    logic [`WFD5_ADDR_W-1:0] addr;
    logic [`WFD5_WORD_W-1:0] data;
  } mem_wr_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

  // packed so that running lands in bit 0
  typedef struct packed {
    logic hdr_empty;
    logic done;
    logic triggered;
    logic running;
  } acq_status_t;

endpackage

// File: wfd5_channel.f
+incdir+verilog
verilog/wfd5_pkg.sv
verilog/adc_sample_packer.sv
verilog/adc_data_mem.sv
verilog/header_fifo.sv
verilog/acquisition_control.sv
verilog/readout_regs.sv
verilog/channel_main.sv
testbench/channel_checker.sv
testbench/tb_channel_main.sv
